// File: Makefile
VERILATOR ?= verilator
TOP       ?= ex_tb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: build
	./$(SIM_BIN) | tee $(LOG)
	@grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: bench/ex_tb.sv
`timescale 1ns/1ps
`include "ex_consts.svh"

module ex_tb import ex_pkg::*; ();

    localparam int N_ALU   = 200;
    localparam int N_DIV   = 24;
    localparam int N_MEM   = 40;
    localparam int N_BAD   = 60;
    localparam int N_MIX   = 120;
    localparam int N_FLUSH = 60;
    localparam int CYCLE_LIMIT =
        40 * (N_ALU + N_DIV + 2 * N_MEM + N_BAD + N_MIX + N_FLUSH) + 200;

    // Expected output record plus the data request it should make
    typedef struct packed {
        ex_mem_t    rec;
        logic       req;
        logic       wr;
        logic [1:0] size;
        word_t      addr;
        logic [3:0] wstrb;
        word_t      wdata;
    } expect_t;

    logic       clk = 1'b0;
    logic       reset;
    logic       flush;
    logic       in_valid;
    id_ex_t     in_rec;
    logic       ex_allow_in;
    logic       mem_allow_in;
    logic       out_valid;
    ex_mem_t    out_rec;
    logic       data_req;
    logic       data_wr;
    logic [1:0] data_size;
    word_t      data_addr;
    logic [3:0] data_wstrb;
    word_t      data_wdata;
    logic       data_addr_ok;
    logic       csr_crmd_da;
    word_t      csr_dmw0;
    word_t      csr_dmw1;

    expect_t    pending[$];
    expect_t    cur;
    logic       req_fire;
    logic       out_fire;
    logic       stall_on = 1'b0;
    word_t      pc_next = 32'h1c00_0000;
    int         cycles = 0;
    int         checks = 0;
    int         errors = 0;
    int         issued = 0;
    int         delivered = 0;
    int         requests = 0;
    int         flushed = 0;
    int         issued_mark = 0;
    int         flushed_mark = 0;
    int         error_mark = 0;

    ex_top uut (
        .clk          (clk),
        .reset        (reset),
        .flush        (flush),
        .in_valid     (in_valid),
        .in_rec       (in_rec),
        .ex_allow_in  (ex_allow_in),
        .mem_allow_in (mem_allow_in),
        .out_valid    (out_valid),
        .out_rec      (out_rec),
        .data_req     (data_req),
        .data_wr      (data_wr),
        .data_size    (data_size),
        .data_addr    (data_addr),
        .data_wstrb   (data_wstrb),
        .data_wdata   (data_wdata),
        .data_addr_ok (data_addr_ok),
        .csr_crmd_da  (csr_crmd_da),
        .csr_dmw0     (csr_dmw0),
        .csr_dmw1     (csr_dmw1)
    );

    always #4 clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic report_error(input string msg);
        errors++;
        $display("error: %s", msg);
    endtask

    function automatic word_t alu_model(input alu_op_e op, input word_t a, input word_t b);
        case (op)
            ALU_ADD:  return a + b;
            ALU_SUB:  return a - b;
            ALU_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
            ALU_AND:  return a & b;
            ALU_OR:   return a | b;
            ALU_NOR:  return ~(a | b);
            ALU_XOR:  return a ^ b;
            ALU_SLL:  return a << b[4:0];
            ALU_SRL:  return a >> b[4:0];
            ALU_SRA:  return $signed(a) >>> b[4:0];
            ALU_LUI:  return b;
            default:  return '0;
        endcase
    endfunction

    function automatic word_t div_model(input div_op_e op, input word_t a, input word_t b);
        logic  sgn;
        word_t ma;
        word_t mb;
        word_t q;
        word_t rm;
        sgn = (op == DIV_DIV) || (op == DIV_MOD);
        ma = (sgn && a[31]) ? -a : a;
        mb = (sgn && b[31]) ? -b : b;
        if (b == '0) begin
            q  = '1;
            rm = a;
        end else begin
            q  = ma / mb;
            rm = ma % mb;
            // Remainder takes the sign of the dividend
            if (sgn && (a[31] ^ b[31])) q = -q;
            if (sgn && a[31]) rm = -rm;
        end
        return (op == DIV_MOD || op == DIV_MODU) ? rm : q;
    endfunction

    function automatic expect_t ex_model(input id_ex_t r, input logic da,
                                         input word_t w0, input word_t w1);
        expect_t   e;
        mem_ctrl_t m;
        word_t     va;
        logic      store;
        logic      word_acc;
        logic      half_acc;
        logic      hit0;
        logic      hit1;
        logic      ale;
        logic      tlbr;
        int        offset;
        int        nbytes;
        int        lane;
        m        = r.mem_ctrl;
        va       = alu_model(r.alu_op, r.src1, r.src2);
        store    = m.mem_en && (m.st_ctrl != '0);
        word_acc = m.mem_en && (m.st_ctrl[`ST_W] || m.ld_ctrl[`LD_W]);
        half_acc = m.mem_en && (m.st_ctrl[`ST_H] || m.ld_ctrl[`LD_H] || m.ld_ctrl[`LD_HU]);
        offset   = int'(va[1:0]);
        nbytes   = word_acc ? 4 : (half_acc ? 2 : 1);
        // An access must start on a multiple of its own size
        ale      = (offset % nbytes) != 0;
        hit0     = w0[`DMW_PLV0_BIT] && (w0[`DMW_VSEG] == va[`DMW_VSEG]);
        hit1     = w1[`DMW_PLV0_BIT] && (w1[`DMW_VSEG] == va[`DMW_VSEG]);
        tlbr     = m.mem_en && !da && !hit0 && !hit1;

        e.req  = m.mem_en && !ale && !tlbr;
        e.wr   = store;
        e.size = word_acc ? 2'd2 : (half_acc ? 2'd1 : 2'd0);
        e.addr = va;
        if (!da && hit0) begin
            e.addr[`DMW_VSEG] = w0[`DMW_PSEG];
        end else if (!da && hit1) begin
            e.addr[`DMW_VSEG] = w1[`DMW_PSEG];
        end
        // Each lane carries the store byte that lands on it
        for (lane = 0; lane < 4; lane++) begin
            e.wstrb[lane]        = store && (lane >= offset) && (lane < offset + nbytes);
            e.wdata[8*lane +: 8] = r.rkd_value[8*(lane % nbytes) +: 8];
        end

        e.rec.pc           = r.pc;
        e.rec.result       = (r.div_op != DIV_NONE) ? div_model(r.div_op, r.src1, r.src2) : va;
        e.rec.rf_we        = r.rf_we && !store && !(ale || tlbr);
        e.rec.rf_waddr     = r.rf_waddr;
        e.rec.ld_ctrl      = m.ld_ctrl;
        e.rec.wait_data_ok = e.req;
        e.rec.except       = ale || tlbr;
        e.rec.excode       = ale ? `EXC_ALE : (tlbr ? `EXC_TLBR : `EXC_NONE);
        return e;
    endfunction

    function automatic id_ex_t make_alu();
        id_ex_t r;
        r.pc        = pc_next;
        pc_next     = pc_next + 32'd4;
        r.alu_op    = alu_op_e'(4'($urandom % 12));
        r.src1      = $urandom;
        r.src2      = $urandom;
        r.rkd_value = $urandom;
        r.div_op    = DIV_NONE;
        r.mem_ctrl  = '0;
        r.rf_we     = ($urandom % 4) != 0;
        r.rf_waddr  = 5'($urandom);
        return r;
    endfunction

    function automatic id_ex_t make_div();
        id_ex_t r;
        r        = make_alu();
        r.alu_op = ALU_ADD;
        r.div_op = div_op_e'(3'(1 + $urandom % 4));
        case ($urandom % 6)
            0: r.src2 = '0;
            1: begin
                r.src1 = 32'h8000_0000;
                r.src2 = '1;
            end
            2: r.src2 = $urandom % 16;
            default: ;
        endcase
        return r;
    endfunction

    // Kinds 0..2 are stores b/h/w, 3..7 loads b/bu/h/hu/w
    function automatic id_ex_t make_mem(input logic aligned, input logic hit);
        id_ex_t r;
        word_t  va;
        int     k;
        r                   = make_alu();
        r.alu_op            = ALU_ADD;
        k                   = $urandom % 8;
        r.mem_ctrl.mem_en   = 1'b1;
        r.mem_ctrl.st_ctrl  = (k < 3) ? (3'b001 << k) : 3'b000;
        r.mem_ctrl.ld_ctrl  = '0;
        case (k)
            3: r.mem_ctrl.ld_ctrl[`LD_B]  = 1'b1;
            4: r.mem_ctrl.ld_ctrl[`LD_BU] = 1'b1;
            5: r.mem_ctrl.ld_ctrl[`LD_H]  = 1'b1;
            6: r.mem_ctrl.ld_ctrl[`LD_HU] = 1'b1;
            7: r.mem_ctrl.ld_ctrl[`LD_W]  = 1'b1;
            default: ;
        endcase
        va = $urandom;
        if (hit) va[31:29] = 3'd4 + 3'($urandom % 2);
        if (aligned && (k == 1 || k == 5 || k == 6)) va[0] = 1'b0;
        if (aligned && (k == 2 || k == 7)) va[1:0] = 2'b00;
        r.src2 = va - r.src1;
        return r;
    endfunction

    function automatic id_ex_t make_mix();
        int k;
        k = $urandom % 10;
        if (k < 6) return make_alu();
        if (k == 6) return make_div();
        return make_mem(1'b1, 1'b1);
    endfunction

    task automatic issue(input id_ex_t r);
        in_rec   = r;
        in_valid = 1'b1;
        @(posedge clk);
        while (!ex_allow_in) @(posedge clk);
        @(negedge clk);
        in_valid = 1'b0;
        repeat ($urandom % 3) @(negedge clk);
    endtask

    task automatic flush_pulse();
        flush = 1'b1;
        @(negedge clk);
        flush = 1'b0;
    endtask

    task automatic drain();
        while (pending.size() != 0) @(negedge clk);
    endtask

    task automatic finish_test(input string name);
        drain();
        $display("%s: %0d instructions, %0d flushed, %0d errors", name,
                 issued - issued_mark, flushed - flushed_mark, errors - error_mark);
        issued_mark  = issued;
        flushed_mark = flushed;
        error_mark   = errors;
    endtask

    // Data RAM responder and memory-stage back-pressure
    always @(negedge clk) begin
        data_addr_ok = ($urandom % 4) != 0;
        mem_allow_in = stall_on ? (($urandom % 3) != 0) : 1'b1;
    end

    always @(posedge clk) begin
        if (!reset) begin
            req_fire = data_req && data_addr_ok;
            out_fire = out_valid && ex_allow_in;
            if (data_req && !mem_allow_in) begin
                report_error("data request raised while mem_allow_in is low");
            end
            if (out_fire) delivered++;
            if (req_fire || out_fire) begin
                if (pending.size() == 0) begin
                    report_error("output seen with no instruction in flight");
                end else begin
                    cur = pending.pop_front();
                    if (req_fire) begin
                        requests++;
                        if (!cur.req) begin
                            report_error("data request from an instruction that makes none");
                        end else begin
                            check_value("data_addr", data_addr, cur.addr);
                            check_value("data_wr", 32'(data_wr), 32'(cur.wr));
                            check_value("data_size", 32'(data_size), 32'(cur.size));
                            check_value("data_wstrb", 32'(data_wstrb), 32'(cur.wstrb));
                            if (cur.wr) check_value("data_wdata", data_wdata, cur.wdata);
                        end
                        if (!out_fire) report_error("request accepted but record did not leave");
                    end
                    if (out_fire) begin
                        if (cur.req && !req_fire) begin
                            report_error("memory record left without an accepted request");
                        end
                        check_value("out_rec.pc", out_rec.pc, cur.rec.pc);
                        check_value("out_rec.result", out_rec.result, cur.rec.result);
                        check_value("out_rec.rf_we", 32'(out_rec.rf_we), 32'(cur.rec.rf_we));
                        check_value("out_rec.rf_waddr", 32'(out_rec.rf_waddr),
                                    32'(cur.rec.rf_waddr));
                        check_value("out_rec.ld_ctrl", 32'(out_rec.ld_ctrl),
                                    32'(cur.rec.ld_ctrl));
                        check_value("out_rec.wait_data_ok", 32'(out_rec.wait_data_ok),
                                    32'(cur.rec.wait_data_ok));
                        check_value("out_rec.except", 32'(out_rec.except), 32'(cur.rec.except));
                        check_value("out_rec.excode", 32'(out_rec.excode), 32'(cur.rec.excode));
                    end
                end
            end
            // The held record dies with the flush
            if (flush && pending.size() != 0) begin
                void'(pending.pop_front());
                flushed++;
            end
            if (in_valid && ex_allow_in && !flush) begin
                pending.push_back(ex_model(in_rec, csr_crmd_da, csr_dmw0, csr_dmw1));
                issued++;
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Simulation FAILED");
            $finish;
        end
    end

    initial begin
        void'($urandom(32'hfda5_0d80));
        reset        = 1'b1;
        flush        = 1'b0;
        in_valid     = 1'b0;
        in_rec       = '0;
        mem_allow_in = 1'b1;
        data_addr_ok = 1'b0;
        csr_crmd_da  = 1'b1;
        // Window 0 maps 0x8... to 0x0..., window 1 maps 0xa... to 0x2...
        csr_dmw0     = 32'h8000_0001;
        csr_dmw1     = 32'ha200_0001;
        repeat (8) @(negedge clk);
        reset = 1'b0;
        if (out_valid || data_req) report_error("out_valid or data_req high after reset");

        repeat (N_ALU) issue(make_alu());
        finish_test("random ALU ops");

        repeat (N_DIV) issue(make_div());
        finish_test("random divide and modulo");

        repeat (N_MEM) issue(make_mem(1'b1, 1'b0));
        drain();
        csr_crmd_da = 1'b0;
        repeat (N_MEM) issue(make_mem(1'b1, 1'b1));
        finish_test("aligned loads and stores");

        repeat (N_BAD) issue(make_mem(1'b0, 1'b0));
        finish_test("misaligned and unmapped accesses");

        stall_on = 1'b1;
        repeat (N_MIX) issue(make_mix());
        finish_test("back-pressure and addr_ok stalls");

        repeat (N_FLUSH) begin
            issue(($urandom % 3 == 0) ? make_div() : make_mix());
            if ($urandom % 2 == 0) begin
                repeat ($urandom % 36) @(negedge clk);
                flush_pulse();
            end
        end
        finish_test("random flush pulses");

        if (issued != delivered + flushed) begin
            report_error("issued count differs from delivered plus flushed");
        end
        $display("checks %0d, errors %0d, issued %0d, delivered %0d, requests %0d, flushed %0d",
                 checks, errors, issued, delivered, requests, flushed);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// File: filelist.f
+incdir+rtl
rtl/ex_pkg.sv
rtl/ex_issue_reg.sv
rtl/ex_alu.sv
rtl/ex_divider.sv
rtl/ex_mem_access.sv
rtl/ex_stage_ctrl.sv
rtl/ex_top.sv
bench/ex_tb.sv

// File: rtl/ex_alu.sv
`timescale 1ns/1ps

module ex_alu import ex_pkg::*; (
    input  alu_op_e alu_op,
    input  word_t   src1,
    input  word_t   src2,
    output word_t   result
);

    logic [4:0] shamt;
    word_t      diff;
    logic       lt_signed;
    logic       lt_unsigned;

    assign shamt = src2[4:0];
    assign diff  = src1 - src2;

    // Signs differ: src1 negative wins, else sign of the difference
    assign lt_signed   = (src1[31] & ~src2[31]) | (~(src1[31] ^ src2[31]) & diff[31]);
    assign lt_unsigned = (src1 < src2);

    always_comb begin
        case (alu_op)
            ALU_ADD:  result = src1 + src2;
            ALU_SUB:  result = diff;
            ALU_SLT:  result = {31'b0, lt_signed};
            ALU_SLTU: result = {31'b0, lt_unsigned};
            ALU_AND:  result = src1 & src2;
            ALU_OR:   result = src1 | src2;
            ALU_NOR:  result = ~(src1 | src2);
            ALU_XOR:  result = src1 ^ src2;
            ALU_SLL:  result = src1 << shamt;
            ALU_SRL:  result = src1 >> shamt;
            ALU_SRA:  result = $signed(src1) >>> shamt;
            ALU_LUI:  result = src2;
            default:  result = '0;
        endcase
    end

endmodule

// File: rtl/ex_consts.svh
`ifndef EX_CONSTS_SVH
`define EX_CONSTS_SVH

// Field widths
`define ALU_OP_W   4
`define DIV_OP_W   3
`define ST_CTRL_W  3
`define LD_CTRL_W  5
`define EXC_W      6

// Store kinds, bit index into st_ctrl
`define ST_B 0
`define ST_H 1
`define ST_W 2

// Load kinds, bit index into ld_ctrl
`define LD_H  0
`define LD_HU 1
`define LD_B  2
`define LD_BU 3
`define LD_W  4

`define EXC_NONE 6'h00
`define EXC_ALE  6'h09
`define EXC_TLBR 6'h3f

// Direct-mapped window layout
`define DMW_VSEG     31:29
`define DMW_PSEG     27:25
`define DMW_PLV0_BIT 0

`define DIV_ITERS 32

`endif

// File: rtl/ex_divider.sv
`timescale 1ns/1ps
`include "ex_consts.svh"

module ex_divider import ex_pkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  logic    start,
    input  div_op_e div_op,
    input  word_t   dividend,
    input  word_t   divisor,
    output word_t   result,
    output logic    busy,
    output logic    done
);

    div_state_e                    state;
    logic [$clog2(`DIV_ITERS):0]   count;
    word_t                         rem;
    word_t                         quo;
    word_t                         dsr;
    logic                          q_neg;
    logic                          r_neg;
    logic                          by_zero;
    logic                          want_rem;
    logic                          is_signed;
    logic [32:0]                   partial;
    word_t                         q_fixed;
    word_t                         r_fixed;

    assign is_signed = (div_op == DIV_DIV) || (div_op == DIV_MOD);

    // Remainder shifted left with the next dividend bit
    assign partial = {rem, quo[31]};

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= DS_IDLE;
        end else begin
            case (state)
                DS_IDLE: begin
                    if (start) begin
                        state <= DS_RUN;
                    end
                end
                DS_RUN: begin
                    if (count == `DIV_ITERS - 1) begin
                        state <= DS_DONE;
                    end
                end
                DS_DONE: begin
                    if (!start) begin
                        state <= DS_IDLE;
                    end
                end
                default: state <= DS_IDLE;
            endcase
        end
    end

    // Work on magnitudes, signs are restored at the output
    always_ff @(posedge clk) begin
        if (state == DS_IDLE && start) begin
            rem      <= '0;
            quo      <= (is_signed && dividend[31]) ? -dividend : dividend;
            dsr      <= (is_signed && divisor[31]) ? -divisor : divisor;
            q_neg    <= is_signed && (dividend[31] ^ divisor[31]);
            r_neg    <= is_signed && dividend[31];
            by_zero  <= (divisor == '0);
            want_rem <= (div_op == DIV_MOD) || (div_op == DIV_MODU);
            count    <= '0;
        end else if (state == DS_RUN) begin
            count <= count + 1'b1;
            if (partial >= {1'b0, dsr}) begin
                rem <= word_t'(partial - {1'b0, dsr});
                quo <= {quo[30:0], 1'b1};
            end else begin
                rem <= partial[31:0];
                quo <= {quo[30:0], 1'b0};
            end
        end
    end

    // Divide by zero: remainder already equals the dividend after sign fix
    assign q_fixed = by_zero ? '1 : (q_neg ? -quo : quo);
    assign r_fixed = r_neg ? -rem : rem;

    assign result = want_rem ? r_fixed : q_fixed;
    assign busy   = (state == DS_RUN);
    assign done   = (state == DS_DONE);

endmodule

// File: rtl/ex_issue_reg.sv
`timescale 1ns/1ps

module ex_issue_reg import ex_pkg::*; (
    input  logic   clk,
    input  logic   reset,
    input  logic   flush,
    input  logic   in_valid,
    input  id_ex_t in_rec,
    input  logic   allow_in,
    output logic   rec_valid,
    output id_ex_t rec
);

    logic load;

    assign load = in_valid & allow_in;

    // Empties when the held record leaves and nothing new arrives
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            rec_valid <= 1'b0;
        end else if (allow_in) begin
            rec_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            rec <= in_rec;
        end
    end

endmodule

// File: rtl/ex_mem_access.sv
`timescale 1ns/1ps
`include "ex_consts.svh"

module ex_mem_access import ex_pkg::*; (
    input  word_t      va,
    input  word_t      rkd_value,
    input  mem_ctrl_t  mem_ctrl,
    input  logic       csr_crmd_da,
    input  word_t      csr_dmw0,
    input  word_t      csr_dmw1,
    output word_t      pa,
    output logic [3:0] wstrb,
    output word_t      wdata,
    output logic [1:0] size,
    output logic       ale,
    output logic       tlbr
);

    logic st_b;
    logic st_h;
    logic st_w;
    logic half_acc;
    logic word_acc;
    logic hit0;
    logic hit1;

    assign st_b = mem_ctrl.mem_en & mem_ctrl.st_ctrl[`ST_B];
    assign st_h = mem_ctrl.mem_en & mem_ctrl.st_ctrl[`ST_H];
    assign st_w = mem_ctrl.mem_en & mem_ctrl.st_ctrl[`ST_W];

    assign half_acc = st_h | (mem_ctrl.mem_en &
                      (mem_ctrl.ld_ctrl[`LD_H] | mem_ctrl.ld_ctrl[`LD_HU]));
    assign word_acc = st_w | (mem_ctrl.mem_en & mem_ctrl.ld_ctrl[`LD_W]);

    // Lane select from the low address bits
    always_comb begin
        wstrb = 4'b0000;
        if (st_b) begin
            wstrb = 4'b0001 << va[1:0];
        end else if (st_h) begin
            wstrb = va[1] ? 4'b1100 : 4'b0011;
        end else if (st_w) begin
            wstrb = 4'b1111;
        end
    end

    assign wdata = st_b ? {4{rkd_value[7:0]}} :
                   st_h ? {2{rkd_value[15:0]}} :
                   rkd_value;

    assign size = word_acc ? 2'd2 : (half_acc ? 2'd1 : 2'd0);

    assign ale = (half_acc & va[0]) | (word_acc & (va[1] | va[0]));

    // A window matches on its enable bit and the top three address bits
    assign hit0 = csr_dmw0[`DMW_PLV0_BIT] & (csr_dmw0[`DMW_VSEG] == va[`DMW_VSEG]);
    assign hit1 = csr_dmw1[`DMW_PLV0_BIT] & (csr_dmw1[`DMW_VSEG] == va[`DMW_VSEG]);

    // No window hit stands in for a TLB refill
    assign tlbr = mem_ctrl.mem_en & ~csr_crmd_da & ~hit0 & ~hit1;

    always_comb begin
        pa = va;
        if (!csr_crmd_da) begin
            if (hit0) begin
                pa[`DMW_VSEG] = csr_dmw0[`DMW_PSEG];
            end else if (hit1) begin
                pa[`DMW_VSEG] = csr_dmw1[`DMW_PSEG];
            end
        end
    end

endmodule

// File: rtl/ex_pkg.sv
`include "ex_consts.svh"

package ex_pkg;

    typedef logic [31:0]       word_t;
    typedef logic [4:0]        reg_addr_t;
    typedef logic [`EXC_W-1:0] exc_code_t;

    typedef enum logic [`ALU_OP_W-1:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLT,
        ALU_SLTU,
        ALU_AND,
        ALU_OR,
        ALU_NOR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_LUI
    } alu_op_e;

    typedef enum logic [`DIV_OP_W-1:0] {
        DIV_NONE,
        DIV_DIV,
        DIV_MOD,
        DIV_DIVU,
        DIV_MODU
    } div_op_e;

    typedef enum logic [1:0] {
        DS_IDLE,
        DS_RUN,
        DS_DONE
    } div_state_e;

    typedef struct packed {
        logic                  mem_en;
        logic [`ST_CTRL_W-1:0] st_ctrl;   // {st_w, st_h, st_b}
        logic [`LD_CTRL_W-1:0] ld_ctrl;
    } mem_ctrl_t;

    // Decoded instruction from decode
    typedef struct packed {
        word_t     pc;
        alu_op_e   alu_op;
        word_t     src1;
        word_t     src2;
        word_t     rkd_value;
        div_op_e   div_op;
        mem_ctrl_t mem_ctrl;
        logic      rf_we;
        reg_addr_t rf_waddr;
    } id_ex_t;

    // Record handed to the memory stage
    typedef struct packed {
        word_t                 pc;
        word_t                 result;
        logic                  rf_we;
        reg_addr_t             rf_waddr;
        logic [`LD_CTRL_W-1:0] ld_ctrl;
        logic                  wait_data_ok;
        logic                  except;
        exc_code_t             excode;
    } ex_mem_t;

endpackage

// File: rtl/ex_stage_ctrl.sv
`timescale 1ns/1ps
`include "ex_consts.svh"

module ex_stage_ctrl import ex_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       flush,
    input  logic       rec_valid,
    input  id_ex_t     rec,
    input  logic       mem_allow_in,
    input  logic       csr_crmd_da,
    input  word_t      csr_dmw0,
    input  word_t      csr_dmw1,
    output logic       data_req,
    output logic       data_wr,
    output logic [1:0] data_size,
    output word_t      data_addr,
    output logic [3:0] data_wstrb,
    output word_t      data_wdata,
    input  logic       data_addr_ok,
    output logic       ex_allow_in,
    output logic       out_valid,
    output ex_mem_t    out_rec
);

    word_t alu_result;
    word_t div_result;
    logic  div_done;
    logic  div_start;
    logic  div_clear;
    logic  is_div;
    logic  is_store;
    logic  has_flush;
    logic  kill;
    logic  ready_go;
    logic  out_fire;
    logic  ale;
    logic  tlbr;
    logic  except;

    ex_alu u_alu (
        .alu_op (rec.alu_op),
        .src1   (rec.src1),
        .src2   (rec.src2),
        .result (alu_result)
    );

    assign is_div    = (rec.div_op != DIV_NONE);
    assign div_start = rec_valid & is_div & ~kill;

    // Back to idle once the record leaves, so a following divide restarts
    assign div_clear = reset | flush | out_fire;

    ex_divider u_div (
        .clk      (clk),
        .reset    (div_clear),
        .start    (div_start),
        .div_op   (rec.div_op),
        .dividend (rec.src1),
        .divisor  (rec.src2),
        .result   (div_result),
        .busy     (),
        .done     (div_done)
    );

    ex_mem_access u_mem (
        .va          (alu_result),
        .rkd_value   (rec.rkd_value),
        .mem_ctrl    (rec.mem_ctrl),
        .csr_crmd_da (csr_crmd_da),
        .csr_dmw0    (csr_dmw0),
        .csr_dmw1    (csr_dmw1),
        .pa          (data_addr),
        .wstrb       (data_wstrb),
        .wdata       (data_wdata),
        .size        (data_size),
        .ale         (ale),
        .tlbr        (tlbr)
    );

    // Flush seen while the record is stuck waiting
    always_ff @(posedge clk) begin
        if (reset || out_fire || !rec_valid) begin
            has_flush <= 1'b0;
        end else if (flush) begin
            has_flush <= 1'b1;
        end
    end

    assign kill     = flush | has_flush;
    assign except   = ale | tlbr;
    assign is_store = |rec.mem_ctrl.st_ctrl;

    assign data_req = rec_valid & rec.mem_ctrl.mem_en & ~except & mem_allow_in & ~kill;
    assign data_wr  = is_store;

    assign ready_go = is_div ? div_done : (data_req ? data_addr_ok : 1'b1);

    assign out_valid   = rec_valid & ~kill;
    assign out_fire    = out_valid & ready_go & mem_allow_in;
    assign ex_allow_in = ~rec_valid | (ready_go & mem_allow_in);

    always_comb begin
        out_rec.pc           = rec.pc;
        out_rec.result       = is_div ? div_result : alu_result;
        out_rec.rf_we        = rec.rf_we & ~is_store & ~except;
        out_rec.rf_waddr     = rec.rf_waddr;
        out_rec.ld_ctrl      = rec.mem_ctrl.ld_ctrl;
        out_rec.wait_data_ok = rec.mem_ctrl.mem_en & ~except;
        out_rec.except       = except;
        // ALE outranks the refill
        out_rec.excode       = ale ? `EXC_ALE : (tlbr ? `EXC_TLBR : `EXC_NONE);
    end

endmodule

// File: rtl/ex_top.sv
`timescale 1ns/1ps

module ex_top import ex_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       flush,
    input  logic       in_valid,
    input  id_ex_t     in_rec,
    output logic       ex_allow_in,
    input  logic       mem_allow_in,
    output logic       out_valid,
    output ex_mem_t    out_rec,
    output logic       data_req,
    output logic       data_wr,
    output logic [1:0] data_size,
    output word_t      data_addr,
    output logic [3:0] data_wstrb,
    output word_t      data_wdata,
    input  logic       data_addr_ok,
    input  logic       csr_crmd_da,
    input  word_t      csr_dmw0,
    input  word_t      csr_dmw1
);

    logic   rec_valid;
    id_ex_t rec;

    ex_issue_reg u_issue (
        .clk       (clk),
        .reset     (reset),
        .flush     (flush),
        .in_valid  (in_valid),
        .in_rec    (in_rec),
        .allow_in  (ex_allow_in),
        .rec_valid (rec_valid),
        .rec       (rec)
    );

    ex_stage_ctrl u_core (
        .clk          (clk),
        .reset        (reset),
        .flush        (flush),
        .rec_valid    (rec_valid),
        .rec          (rec),
        .mem_allow_in (mem_allow_in),
        .csr_crmd_da  (csr_crmd_da),
        .csr_dmw0     (csr_dmw0),
        .csr_dmw1     (csr_dmw1),
        .data_req     (data_req),
        .data_wr      (data_wr),
        .data_size    (data_size),
        .data_addr    (data_addr),
        .data_wstrb   (data_wstrb),
        .data_wdata   (data_wdata),
        .data_addr_ok (data_addr_ok),
        .ex_allow_in  (ex_allow_in),
        .out_valid    (out_valid),
        .out_rec      (out_rec)
    );

endmodule
